// File: design/arcade_pkg.sv
// Cabinet-side types for the tank game: joystick, tread command, cabinet input byte, variant
package arcade_pkg;

	////////////////////
	// Player controls
	////////////////////

	// One player's joystick byte
	// Bit order follows the host joystick word, right in bit 0 and coin in bit 7
	typedef struct packed {
		logic coin;
		logic start_2p;
		logic start_1p;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joystick_t;

	// Tread drive, one forward and one back bit per side
	typedef struct packed {
		logic left_fw;
		logic left_bk;
		logic right_fw;
		logic right_bk;
	} tread_cmd_t;

	// Byte seen by the game core on its input port
	typedef struct packed {
		logic       coin;
		logic       start_2p;
		logic       start_1p;
		logic       fire;
		tread_cmd_t treads;
	} cabinet_in_t;

	////////////////////
	// Game variant
	////////////////////

	// Selected by the host before the ROM download
	typedef enum logic [7:0] {
		VARIANT_BATTLEZONE = 8'd0,
		VARIANT_BRADLEY    = 8'd1,
		VARIANT_REDBARON   = 8'd2,
		VARIANT_NONE       = 8'd255
	} variant_t;

endpackage

// File: design/download_pkg.sv
// Host download types: incoming beat, ROM write beat and download index codes
package download_pkg;

	////////////////////
	// Beat formats
	////////////////////

	// One byte from the host download stream
	typedef struct packed {
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_beat_t;

	// Write toward the 64K program memory
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
	} rom_beat_t;

	////////////////////
	// Index codes
	////////////////////

	// Program ROM image
	localparam logic [7:0] IDX_ROM     = 8'd0;
	// Variant selection byte
	localparam logic [7:0] IDX_VARIANT = 8'd1;
	// DIP switch bytes
	localparam logic [7:0] IDX_DIPS    = 8'd254;

endpackage

// File: design/tread_mapper.sv
// Joystick merge and eight-way tread decode, registered into the cabinet input byte
`timescale 1ns/1ps

module tread_mapper
	import arcade_pkg::*;
(
	input  logic        clk_25,
	input  logic        arst_n,
	input  joystick_t   joy_p1,
	input  joystick_t   joy_p2,
	output cabinet_in_t cabinet_in
);

	joystick_t  merged;
	tread_cmd_t treads;

	// Either player may drive the single tank
	assign merged = joy_p1 | joy_p2;

	////////////////////
	// Direction table
	////////////////////

	// Order is up, down, left, right
	always_comb begin
		treads = '0;
		case ({merged.up, merged.down, merged.left, merged.right})
			// Up, both treads forward
			4'b1000: treads = '{left_fw: 1'b1, left_bk: 1'b0, right_fw: 1'b1, right_bk: 1'b0};
			// Up-left, pivot on the left tread
			4'b1010: treads.right_fw = 1'b1;
			// Up-right, pivot on the right tread
			4'b1001: treads.left_fw = 1'b1;
			// Right, spin in place clockwise
			4'b0001: treads = '{left_fw: 1'b1, left_bk: 1'b0, right_fw: 1'b0, right_bk: 1'b1};
			// Down-right
			4'b0101: treads.left_bk = 1'b1;
			// Down, both treads back
			4'b0100: treads = '{left_fw: 1'b0, left_bk: 1'b1, right_fw: 1'b0, right_bk: 1'b1};
			// Left, spin counter-clockwise
			4'b0010: treads = '{left_fw: 1'b0, left_bk: 1'b1, right_fw: 1'b1, right_bk: 1'b0};
			// Down-left
			4'b0110: treads.right_bk = 1'b1;
			// Conflicting or idle stick, tank stops
			default: treads = '0;
		endcase
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			cabinet_in <= '0;
		end else begin
			cabinet_in.coin     <= merged.coin;
			cabinet_in.start_2p <= merged.start_2p;
			cabinet_in.start_1p <= merged.start_1p;
			cabinet_in.fire     <= merged.fire;
			cabinet_in.treads   <= treads;
		end
	end

endmodule

// File: design/download_router.sv
// Download beat router by index, with the credit count for the ROM write queue
`timescale 1ns/1ps

module download_router
	import download_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic      clk_25,
	input  logic      arst_n,
	input  logic      dl_valid,
	input  dl_beat_t  dl_beat,
	output logic      dl_busy,
	output logic      rom_push,
	output rom_beat_t rom_push_beat,
	input  logic      credit_return,
	output logic      cfg_wr,
	output dl_beat_t  cfg_beat
);

	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	logic [CW-1:0] credit_cnt;
	logic          is_rom;
	logic          is_cfg;
	logic          rom_take;

	// Index decode
	assign is_rom   = dl_valid && (dl_beat.index == IDX_ROM);
	assign is_cfg   = dl_valid && (dl_beat.index == IDX_VARIANT || dl_beat.index == IDX_DIPS);
	// A ROM beat only goes out with a credit in hand, so the queue never overflows
	assign rom_take = is_rom && !dl_busy;
	// Out of credits, host has to wait
	assign dl_busy  = (credit_cnt == '0);

	// Strobes
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			rom_push <= 1'b0;
			cfg_wr   <= 1'b0;
		end else begin
			rom_push <= rom_take;
			cfg_wr   <= is_cfg;
		end
	end

	// Payloads, qualified by the strobes above
	always_ff @(posedge clk_25) begin
		if (rom_take) begin
			rom_push_beat.addr <= dl_beat.addr[15:0];
			rom_push_beat.data <= dl_beat.data;
		end
		if (is_cfg) begin
			cfg_beat <= dl_beat;
		end
	end

	////////////////////
	// Credit counter
	////////////////////

	// Spent on acceptance, restored by the queue's return pulse
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			credit_cnt <= CW'(QUEUE_DEPTH);
		end else begin
			case ({rom_take, credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Host honours dl_busy for ROM beats
	a_no_rom_when_busy: assert property (@(posedge clk_25) disable iff (!arst_n)
		(dl_valid && dl_beat.index == IDX_ROM) |-> !dl_busy)
		else $error("ROM beat sent with no credits");

	// Queue returns no more credits than were spent
	a_credit_bound: assert property (@(posedge clk_25) disable iff (!arst_n)
		credit_cnt <= CW'(QUEUE_DEPTH))
		else $error("credit count above queue depth");

endmodule

// File: design/core_config.sv
// Variant, DIP switch and core hold registers written from the download stream
`timescale 1ns/1ps

module core_config
	import arcade_pkg::*;
	import download_pkg::*;
(
	input  logic       clk_25,
	input  logic       arst_n,
	input  logic       cfg_wr,
	input  dl_beat_t   cfg_beat,
	input  logic       dl_active,
	input  logic       reset_req,
	output variant_t   variant,
	output logic [7:0] dip_bank_0,
	output logic [7:0] dip_bank_1,
	output logic       core_hold
);

	logic [7:0] dip_sw [8];
	logic       variant_wr;
	logic       dip_wr;

	assign variant_wr = cfg_wr && (cfg_beat.index == IDX_VARIANT);
	// Only addresses 0..7 map onto a switch byte
	assign dip_wr     = cfg_wr && (cfg_beat.index == IDX_DIPS) && (cfg_beat.addr[24:3] == '0);

	////////////////////
	// Variant
	////////////////////

	// No variant until the host sends one
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			variant <= VARIANT_NONE;
		end else if (variant_wr) begin
			variant <= variant_t'(cfg_beat.data);
		end
	end

	////////////////////
	// DIP switches
	////////////////////

	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				dip_sw[i] <= '0;
			end
		end else if (dip_wr) begin
			dip_sw[cfg_beat.addr[2:0]] <= cfg_beat.data;
		end
	end

	// The game board reads two banks
	assign dip_bank_0 = dip_sw[0];
	assign dip_bank_1 = dip_sw[1];

	// Core stays stopped during a ROM load or a host reset
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			core_hold <= 1'b1;
		end else begin
			core_hold <= dl_active || reset_req;
		end
	end

endmodule

// File: design/rom_write_queue.sv
// Credit-returning FIFO of ROM write beats in front of the program memory
`timescale 1ns/1ps

module rom_write_queue
	import download_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic      clk_25,
	input  logic      arst_n,
	input  logic      rom_push,
	input  rom_beat_t rom_push_beat,
	output logic      credit_return,
	output logic      mem_wr,
	output rom_beat_t mem_beat,
	input  logic      mem_ready
);

	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	rom_beat_t     slots [QUEUE_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] fill;
	logic          pop;

	// Head of queue is always on offer
	assign mem_wr   = (fill != '0);
	assign mem_beat = slots[rd_ptr];
	// Memory takes the head this cycle
	assign pop      = mem_wr && mem_ready;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk_25) begin
		if (rom_push) begin
			slots[wr_ptr] <= rom_push_beat;
		end
	end

	////////////////////
	// Pointers and fill
	////////////////////

	// Explicit wrap keeps non-power-of-two depths legal
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (rom_push) begin
				wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			fill <= '0;
		end else begin
			case ({rom_push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// One credit back per entry that left, a cycle later
	always_ff @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

	// Router credits keep pushes away from a full queue
	a_no_push_full: assert property (@(posedge clk_25) disable iff (!arst_n)
		rom_push |-> (fill != CW'(QUEUE_DEPTH)))
		else $error("push into full ROM queue");

	// Stalled write holds its beat until memory takes it
	a_hold_stalled: assert property (@(posedge clk_25) disable iff (!arst_n)
		(mem_wr && !mem_ready) |=> (mem_wr && $stable(mem_beat)))
		else $error("mem_beat changed during stall");

endmodule

// File: design/tank_control_top.sv
// Tank game control front end: joystick decode, download routing, config and ROM queue
`timescale 1ns/1ps

module tank_control_top
	import arcade_pkg::*;
	import download_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clk_25,
	input  logic        arst_n,
	input  joystick_t   joy_p1,
	input  joystick_t   joy_p2,
	input  logic        dl_valid,
	input  dl_beat_t    dl_beat,
	input  logic        dl_active,
	input  logic        reset_req,
	output logic        dl_busy,
	output cabinet_in_t cabinet_in,
	output variant_t    variant,
	output logic [7:0]  dip_bank_0,
	output logic [7:0]  dip_bank_1,
	output logic        core_hold,
	output logic        mem_wr,
	output rom_beat_t   mem_beat,
	input  logic        mem_ready
);

	// Router to queue
	logic      rom_push;
	rom_beat_t rom_push_beat;
	logic      credit_return;
	// Router to config block
	logic      cfg_wr;
	dl_beat_t  cfg_beat;

	////////////////////
	// Cabinet inputs
	////////////////////

	tread_mapper u_tread_mapper (
		.clk_25     (clk_25),
		.arst_n     (arst_n),
		.joy_p1     (joy_p1),
		.joy_p2     (joy_p2),
		.cabinet_in (cabinet_in)
	);

	////////////////////
	// Download path
	////////////////////

	download_router #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_download_router (
		.clk_25        (clk_25),
		.arst_n        (arst_n),
		.dl_valid      (dl_valid),
		.dl_beat       (dl_beat),
		.dl_busy       (dl_busy),
		.rom_push      (rom_push),
		.rom_push_beat (rom_push_beat),
		.credit_return (credit_return),
		.cfg_wr        (cfg_wr),
		.cfg_beat      (cfg_beat)
	);

	// Depth here must match the router's credit count
	rom_write_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_rom_write_queue (
		.clk_25        (clk_25),
		.arst_n        (arst_n),
		.rom_push      (rom_push),
		.rom_push_beat (rom_push_beat),
		.credit_return (credit_return),
		.mem_wr        (mem_wr),
		.mem_beat      (mem_beat),
		.mem_ready     (mem_ready)
	);

	core_config u_core_config (
		.clk_25     (clk_25),
		.arst_n     (arst_n),
		.cfg_wr     (cfg_wr),
		.cfg_beat   (cfg_beat),
		.dl_active  (dl_active),
		.reset_req  (reset_req),
		.variant    (variant),
		.dip_bank_0 (dip_bank_0),
		.dip_bank_1 (dip_bank_1),
		.core_hold  (core_hold)
	);

endmodule

// File: verification/tb_tank_control.sv
// Testbench for the tank control front end covering treads, ROM ordering, credits, config and hold
`timescale 1ns/1ps

module tb_tank_control
	import arcade_pkg::*;
	import download_pkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	localparam int WAIT_LIMIT  = 400;

	logic        clk_25 = 1'b0;
	logic        arst_n;
	joystick_t   joy_p1;
	joystick_t   joy_p2;
	logic        dl_valid;
	dl_beat_t    dl_beat;
	logic        dl_active;
	logic        reset_req;
	logic        dl_busy;
	cabinet_in_t cabinet_in;
	variant_t    variant;
	logic [7:0]  dip_bank_0;
	logic [7:0]  dip_bank_1;
	logic        core_hold;
	logic        mem_wr;
	rom_beat_t   mem_beat;
	logic        mem_ready;

	int          seed = 40;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	// Memory side pacing is random or a fixed level
	logic        ready_random;
	logic        ready_level;
	// Scoreboard of ROM beats still owed to memory
	rom_beat_t   exp_q [$];
	rom_beat_t   exp_head;
	int          exp_cnt;
	// Expected cabinet byte and hold flag
	cabinet_in_t cab_exp;
	logic        hold_exp;

	always #20 clk_25 = ~clk_25;

	tank_control_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) uut (
		.clk_25     (clk_25),
		.arst_n     (arst_n),
		.joy_p1     (joy_p1),
		.joy_p2     (joy_p2),
		.dl_valid   (dl_valid),
		.dl_beat    (dl_beat),
		.dl_active  (dl_active),
		.reset_req  (reset_req),
		.dl_busy    (dl_busy),
		.cabinet_in (cabinet_in),
		.variant    (variant),
		.dip_bank_0 (dip_bank_0),
		.dip_bank_1 (dip_bank_1),
		.core_hold  (core_hold),
		.mem_wr     (mem_wr),
		.mem_beat   (mem_beat),
		.mem_ready  (mem_ready)
	);

	////////////////////
	// Reference model
	////////////////////

	// Tread speeds as signed sums with steering mirrored when reversing
	function automatic tread_cmd_t expected_treads(input joystick_t j);
		int         v;
		int         h;
		int         l;
		int         r;
		tread_cmd_t t;
		t = '0;
		// Opposing directions on one axis stop the tank
		if ((j.up && j.down) || (j.left && j.right)) begin
			return t;
		end
		v = int'(j.up) - int'(j.down);
		h = int'(j.right) - int'(j.left);
		if (v < 0) begin
			l = v - h;
			r = v + h;
		end else begin
			l = v + h;
			r = v - h;
		end
		t.left_fw  = (l > 0);
		t.left_bk  = (l < 0);
		t.right_fw = (r > 0);
		t.right_bk = (r < 0);
		return t;
	endfunction

	function automatic cabinet_in_t expected_cabinet(input joystick_t j);
		cabinet_in_t c;
		c.coin     = j.coin;
		c.start_2p = j.start_2p;
		c.start_1p = j.start_1p;
		c.fire     = j.fire;
		c.treads   = expected_treads(j);
		return c;
	endfunction

	// One cycle behind the inputs like the DUT registers
	always @(posedge clk_25 or negedge arst_n) begin
		if (!arst_n) begin
			cab_exp  <= '0;
			hold_exp <= 1'b1;
		end else begin
			cab_exp  <= expected_cabinet(joy_p1 | joy_p2);
			hold_exp <= dl_active || reset_req;
		end
	end

	// Memory pacing
	always @(posedge clk_25) begin
		if (ready_random) begin
			mem_ready <= 1'(unsigned'($random(seed)));
		end else begin
			mem_ready <= ready_level;
		end
	end

	// Retire the head when memory takes a beat
	always @(posedge clk_25) begin
		if (arst_n && mem_wr && mem_ready && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
		end
	end

	// Head snapshot settles before the next rising edge
	always @(negedge clk_25) begin
		exp_cnt = exp_q.size();
		if (exp_cnt != 0) begin
			exp_head = exp_q[0];
		end
	end

	////////////////////
	// Checkers
	////////////////////

	a_cabinet: assert property (@(posedge clk_25) disable iff (!arst_n)
		cabinet_in == cab_exp)
		else begin
			errors++;
			$display("mismatch cabinet_in got %h exp %h", $sampled(cabinet_in), $sampled(cab_exp));
		end

	a_core_hold: assert property (@(posedge clk_25) disable iff (!arst_n)
		core_hold == hold_exp)
		else begin
			errors++;
			$display("mismatch core_hold got %h exp %h", $sampled(core_hold), $sampled(hold_exp));
		end

	// Every memory write must be the oldest beat sent
	a_rom_order: assert property (@(posedge clk_25) disable iff (!arst_n)
		(mem_wr && mem_ready) |-> (exp_cnt != 0 && mem_beat == exp_head))
		else begin
			errors++;
			if ($sampled(exp_cnt) == 0) begin
				$display("memory write seen with no ROM beat outstanding");
			end else begin
				$display("mismatch mem_beat got %h exp %h", $sampled(mem_beat), $sampled(exp_head));
			end
		end

	a_stall_hold: assert property (@(posedge clk_25) disable iff (!arst_n)
		(mem_wr && !mem_ready) |=> (mem_wr && $stable(mem_beat)))
		else begin
			errors++;
			$display("stalled memory write was dropped or changed");
		end

	////////////////////
	// Helpers
	////////////////////

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_start);
		end
	endtask

	// One beat for one cycle with ROM beats held back until a credit is free
	task automatic send_beat(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		int        waited;
		dl_beat_t  beat;
		rom_beat_t exp_beat;
		waited = 0;
		beat = '{index: index, addr: addr, data: data};
		@(negedge clk_25);
		while (index == IDX_ROM && dl_busy && waited < WAIT_LIMIT) begin
			@(negedge clk_25);
			waited++;
		end
		if (index == IDX_ROM && dl_busy) begin
			errors++;
			$display("timeout waiting for dl_busy to clear, ROM beat not sent");
		end else begin
			@(posedge clk_25);
			dl_valid <= 1'b1;
			dl_beat  <= beat;
			if (index == IDX_ROM) begin
				exp_beat.addr = addr[15:0];
				exp_beat.data = data;
				exp_q.push_back(exp_beat);
			end
			@(posedge clk_25);
			dl_valid <= 1'b0;
		end
	endtask

	// Router stage then register stage
	task automatic settle_config();
		@(posedge clk_25);
		@(negedge clk_25);
	endtask

	task automatic wait_drained(input string what);
		int waited;
		waited = 0;
		@(negedge clk_25);
		while ((exp_q.size() != 0 || dl_busy) && waited < WAIT_LIMIT) begin
			@(negedge clk_25);
			waited++;
		end
		if (exp_q.size() != 0 || dl_busy) begin
			errors++;
			$display("timeout in %s, %0d ROM beats never reached memory", what, exp_q.size());
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic reset_state();
		int err_start;
		int waited;
		err_start = errors;
		waited = 0;
		repeat (15) @(posedge clk_25);
		@(negedge clk_25);
		check_hex("mem_wr", mem_wr, 0);
		check_hex("dl_busy", dl_busy, 0);
		check_hex("cabinet_in", cabinet_in, 0);
		check_hex("variant", variant, 8'hff);
		check_hex("dip_bank_0", dip_bank_0, 0);
		check_hex("dip_bank_1", dip_bank_1, 0);
		check_hex("core_hold", core_hold, 1);
		@(posedge clk_25);
		arst_n <= 1'b1;
		// Hold drops once the host lines are quiet
		@(negedge clk_25);
		while (core_hold && waited < 8) begin
			@(negedge clk_25);
			waited++;
		end
		if (core_hold) begin
			errors++;
			$display("core_hold stayed high after reset release");
		end
		finish_test("reset state", err_start);
	endtask

	task automatic tread_table();
		int         err_start;
		logic [3:0] dirs;
		joystick_t  j1;
		joystick_t  j2;
		err_start = errors;
		for (int code = 0; code < 16; code++) begin
			dirs = code[3:0];
			j1 = 8'(unsigned'($random(seed)));
			j2 = 8'(unsigned'($random(seed)));
			// Vertical and horizontal halves come from different players
			{j1.up, j1.down, j1.left, j1.right} = code[0] ? {dirs[3:2], 2'b00} : {2'b00, dirs[1:0]};
			{j2.up, j2.down, j2.left, j2.right} = code[0] ? {2'b00, dirs[1:0]} : {dirs[3:2], 2'b00};
			@(posedge clk_25);
			joy_p1 <= j1;
			joy_p2 <= j2;
			@(posedge clk_25);
		end
		@(posedge clk_25);
		joy_p1 <= '0;
		joy_p2 <= '0;
		repeat (2) @(posedge clk_25);
		finish_test("tread table", err_start);
	endtask

	task automatic rom_ordering();
		int err_start;
		err_start = errors;
		@(posedge clk_25);
		ready_random <= 1'b1;
		for (int i = 0; i < 40; i++) begin
			send_beat(IDX_ROM, 25'(unsigned'($random(seed))), 8'(unsigned'($random(seed))));
		end
		wait_drained("ROM ordering");
		finish_test("ROM ordering", err_start);
	endtask

	task automatic back_pressure();
		int err_start;
		int waited;
		err_start = errors;
		waited = 0;
		@(posedge clk_25);
		ready_random <= 1'b0;
		ready_level  <= 1'b0;
		repeat (2) @(posedge clk_25);
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			@(negedge clk_25);
			check_hex("dl_busy", dl_busy, 0);
			send_beat(IDX_ROM, 25'(unsigned'($random(seed))), 8'(unsigned'($random(seed))));
		end
		@(negedge clk_25);
		while (!dl_busy && waited < 4) begin
			@(negedge clk_25);
			waited++;
		end
		if (!dl_busy) begin
			errors++;
			$display("dl_busy did not rise after %0d ROM beats", QUEUE_DEPTH);
		end
		// Nothing may leave the full queue
		repeat (6) begin
			@(negedge clk_25);
			check_hex("dl_busy", dl_busy, 1);
			check_hex("mem_wr", mem_wr, 1);
		end
		@(posedge clk_25);
		ready_level <= 1'b1;
		wait_drained("back-pressure release");
		finish_test("back-pressure", err_start);
	endtask

	task automatic config_writes();
		int         err_start;
		logic [7:0] d0;
		logic [7:0] d1;
		err_start = errors;
		d0 = 8'(unsigned'($random(seed)));
		d1 = 8'(unsigned'($random(seed)));
		send_beat(IDX_VARIANT, 25'd0, VARIANT_REDBARON);
		settle_config();
		check_hex("variant", variant, VARIANT_REDBARON);
		send_beat(IDX_VARIANT, 25'd0, VARIANT_BRADLEY);
		settle_config();
		check_hex("variant", variant, VARIANT_BRADLEY);
		send_beat(IDX_DIPS, 25'd0, d0);
		send_beat(IDX_DIPS, 25'd1, d1);
		settle_config();
		check_hex("dip_bank_0", dip_bank_0, d0);
		check_hex("dip_bank_1", dip_bank_1, d1);
		// Out of range writes whose low bits alias banks 0 and 1
		send_beat(IDX_DIPS, 25'd8, ~d0);
		send_beat(IDX_DIPS, 25'd9, ~d1);
		send_beat(IDX_DIPS, 25'h1000000, ~d0);
		// Unknown index is dropped
		send_beat(8'd7, 25'd0, ~d0);
		send_beat(8'd7, 25'd1, VARIANT_BATTLEZONE);
		settle_config();
		check_hex("dip_bank_0", dip_bank_0, d0);
		check_hex("dip_bank_1", dip_bank_1, d1);
		check_hex("variant", variant, VARIANT_BRADLEY);
		repeat (3) @(negedge clk_25);
		check_hex("mem_wr", mem_wr, 0);
		finish_test("configuration", err_start);
	endtask

	task automatic hold_tracking();
		int err_start;
		int waited;
		err_start = errors;
		waited = 0;
		for (int i = 0; i < 24; i++) begin
			@(posedge clk_25);
			dl_active <= 1'(unsigned'($random(seed)));
			reset_req <= 1'(unsigned'($random(seed)));
		end
		@(posedge clk_25);
		dl_active <= 1'b0;
		reset_req <= 1'b0;
		@(negedge clk_25);
		while (core_hold && waited < 8) begin
			@(negedge clk_25);
			waited++;
		end
		if (core_hold) begin
			errors++;
			$display("core_hold stayed high with dl_active and reset_req low");
		end
		finish_test("core hold", err_start);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		arst_n       = 1'b0;
		joy_p1       = '0;
		joy_p2       = '0;
		dl_valid     = 1'b0;
		dl_beat      = '0;
		dl_active    = 1'b0;
		reset_req    = 1'b0;
		mem_ready    = 1'b0;
		ready_random = 1'b0;
		ready_level  = 1'b0;
		exp_cnt      = 0;
		exp_head     = '0;

		reset_state();
		tread_table();
		rom_ordering();
		back_pressure();
		config_writes();
		hold_tracking();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: files.f
design/arcade_pkg.sv
design/download_pkg.sv
design/tread_mapper.sv
design/download_router.sv
design/core_config.sv
design/rom_write_queue.sv
design/tank_control_top.sv
verification/tb_tank_control.sv
